// ==== files.f ====
+incdir+test
verilog/scc_types_pkg.sv
verilog/scc_reg_pkg.sv
verilog/scc_fifo.sv
verilog/scc_baud_gen.sv
verilog/scc_tx.sv
verilog/scc_rx.sv
verilog/scc_channel.sv
verilog/scc_iigs_wrapper.sv
test/scc_tb.sv

// ==== test/scc_tb_tasks.svh ====
`ifndef SCC_TB_TASKS_SVH
`define SCC_TB_TASKS_SVH

// One IIgs bus cycle, held until ph0_en and cs meet at a clock edge
task automatic bus_access(input logic ch, input logic data_sel, input logic write,
                          input logic [7:0] wbyte, output logic [7:0] rbyte);
    @(posedge clk_14m);
    cs    <= 1'b1;
    we    <= write;
    rs    <= {data_sel, ch};     // [1] data port, [0] channel A
    wdata <= wbyte;
    do
        @(posedge clk_14m);
    while (!(ph0_en && cs));     // DUT took the strobe on this edge
    cs <= 1'b0;
    @(posedge clk_14m);
    rbyte = rdata;               // Registered on the strobe edge
endtask

// Control writes go through the WR0 pointer unless the target is WR0 itself
task automatic reg_write(input logic ch, input logic [4:0] regn, input logic [7:0] value);
    logic [7:0] ignored;
    if (regn == DATA_PORT) begin
        bus_access(ch, 1'b1, 1'b1, value, ignored);
    end else begin
        if (regn != 5'd0)
            bus_access(ch, 1'b0, 1'b1, {4'h0, regn[3:0]}, ignored); // Pointer
        bus_access(ch, 1'b0, 1'b1, value, ignored);
    end
endtask

task automatic reg_read(input logic ch, input logic [4:0] regn, output logic [7:0] value);
    logic [7:0] ignored;
    if (regn == DATA_PORT) begin
        bus_access(ch, 1'b1, 1'b0, 8'h00, value); // Pops the receive FIFO
    end else begin
        if (regn != 5'd0)
            bus_access(ch, 1'b0, 1'b1, {4'h0, regn[3:0]}, ignored);
        bus_access(ch, 1'b0, 1'b0, 8'h00, value);
    end
endtask

task automatic check_byte(input logic [7:0] got, input logic [7:0] want, input string what);
    if (got !== want) begin
        byte_errors++;
        $display("[FAIL] %0t: %s read %02h, expected %02h", $time, what, got, want);
    end
endtask

task automatic check_irq(input logic got, input logic want, input string what);
    if (got !== want) begin
        irq_errors++;
        $display("[FAIL] %0t: %s irq_n is %b, expected %b", $time, what, got, want);
    end
endtask

task automatic check_status(input scc_types_pkg::scc_ch_status_t got,
                            input scc_types_pkg::scc_ch_status_t want, input string what);
    if (got !== want) begin
        status_errors++;
        $display("[FAIL] %0t: %s status %06b, expected %06b", $time, what, got, want);
    end
endtask

task automatic check_pins(input logic [3:0] got, input logic [3:0] want, input string what);
    if (got !== want) begin
        pin_errors++;
        $display("[FAIL] %0t: %s pins %04b, expected %04b", $time, what, got, want);
    end
endtask

// Limit scales with the table, 20 character times per row
task automatic wait_timeout(input int n_rows);
    longint limit_ns;
    limit_ns = longint'(n_rows) * 20 * CHAR_NS;
    #(limit_ns);
    $display("Watchdog expired after %0d ns, the DUT stopped responding", limit_ns);
endtask

`endif

// ==== test/scc_tb.sv ====
`timescale 1ns/1ps

module scc_tb;
    localparam int         CLK_PERIOD = 20;
    localparam int         BIT_CLKS   = scc_reg_pkg::OVERSAMPLE * scc_reg_pkg::PCLK_DIV;
    localparam int         CHAR_NS    = 10 * BIT_CLKS * CLK_PERIOD; // 8N1 frame at TC 0
    localparam logic [4:0] DATA_PORT  = 5'h10;  // Not a register number, selects rs[1]
    localparam logic       CH_A       = 1'b1;
    localparam logic       CH_B       = 1'b0;

    typedef enum logic [3:0] {
        OP_WRITE, OP_READ, OP_WAIT, OP_FRAME, OP_IRQ, OP_STATUS, OP_PINS, OP_CTS, OP_WATCH
    } op_t;

    typedef struct packed {
        logic       ch;    // 1 = A
        op_t        op;
        logic [4:0] regn;  // Register number or DATA_PORT
        logic [7:0] data;  // Write byte, poll mask, frame byte
        logic [7:0] want;  // Expected value
    } row_t;

    logic       clk_14m, reset, ph0_en, cs, we;
    logic [1:0] rs;
    logic [7:0] wdata, rdata;
    logic       irq_n, txd_a, txd_b, rxd_a, rxd_b;
    logic       rts_a, rts_b, cts_a, cts_b;
    logic [1:0] ph0_cnt;
    logic       raw_sel, raw_line;   // Hand-built frame onto rxd_b
    logic       watch_txd;
    logic       table_ready;
    int         byte_errors, irq_errors, status_errors, pin_errors, line_errors;
    row_t       rows [$];

    `include "scc_tb_tasks.svh"

    always #(CLK_PERIOD / 2) clk_14m = ~clk_14m;

    always @(posedge clk_14m) begin
        ph0_cnt <= ph0_cnt + 1'b1;
        ph0_en  <= (ph0_cnt == 2'd3);    // One bus cycle in four
    end

    assign rxd_b = raw_sel ? raw_line : txd_a;  // A talks to B
    assign rxd_a = txd_b;

    // txd_a must sit at mark while loopback is on
    always @(posedge clk_14m) begin
        if (watch_txd && txd_a !== 1'b1) begin
            if (line_errors == 0)
                $display("[FAIL] %0t: txd_a left the idle level during loopback", $time);
            line_errors++;
        end
    end

    scc_iigs_wrapper scc_iigs_wrapper_i (
        .clk_14m (clk_14m), .reset (reset), .ph0_en (ph0_en), .cs (cs), .we (we),
        .rs (rs), .wdata (wdata), .rdata (rdata), .irq_n (irq_n),
        .txd_a (txd_a), .txd_b (txd_b), .rxd_a (rxd_a), .rxd_b (rxd_b),
        .rts_a (rts_a), .rts_b (rts_b), .cts_a (cts_a), .cts_b (cts_b)
    );

    task automatic poll_reg(input logic ch, input logic [4:0] regn, input logic [7:0] mask,
                            input logic [7:0] want);
        logic [7:0] value;
        reg_read(ch, regn, value);
        while ((value & mask) !== want)
            reg_read(ch, regn, value);
    endtask

    task automatic read_status(input logic ch, output scc_types_pkg::scc_ch_status_t st);
        logic [7:0] r0;
        logic [7:0] r1;
        reg_read(ch, scc_reg_pkg::RR0, r0);
        reg_read(ch, scc_reg_pkg::RR1, r1);  // Clears the sticky bits
        st.rx_avail    = r0[scc_reg_pkg::RR0_RX_AVAIL];
        st.tx_empty    = r0[scc_reg_pkg::RR0_TX_EMPTY];
        st.all_sent    = r1[scc_reg_pkg::RR1_ALL_SENT];
        st.cts         = r0[scc_reg_pkg::RR0_CTS];
        st.overrun     = r1[scc_reg_pkg::RR1_OVERRUN];
        st.framing_err = r1[scc_reg_pkg::RR1_FRAMING];
    endtask

    // Start, LSB first, chosen stop level, then one idle bit
    task automatic send_frame(input logic [7:0] value, input logic stop);
        logic [9:0] bits;
        bits = {stop, value, 1'b0};
        @(posedge clk_14m);
        raw_sel <= 1'b1;
        for (int i = 0; i < 10; i++) begin
            raw_line <= bits[i];
            repeat (BIT_CLKS) @(posedge clk_14m);
        end
        raw_line <= 1'b1;
        repeat (BIT_CLKS) @(posedge clk_14m);
        raw_sel <= 1'b0;
    endtask

    task automatic add_row(input logic ch, input op_t op, input logic [4:0] regn,
                           input logic [7:0] data, input logic [7:0] want);
        rows.push_back('{ch, op, regn, data, want});
    endtask

    task automatic build_table();
        logic [7:0] lo, hi, b;
        logic [7:0] burst [4];
        // Reset state, RTS and CTS
        add_row(CH_A, OP_READ, scc_reg_pkg::RR0, 8'h00, 8'h04);
        add_row(CH_B, OP_READ, scc_reg_pkg::RR0, 8'h00, 8'h04);
        add_row(CH_A, OP_STATUS, 5'd0, 8'h00, 8'b011000);
        add_row(CH_A, OP_IRQ, 5'd0, 8'h00, 8'h01);
        add_row(CH_A, OP_PINS, 5'd0, 8'h00, 8'b1100);     // {txd_a, txd_b, rts_a, rts_b}
        add_row(CH_A, OP_WRITE, scc_reg_pkg::WR5_TX, 8'h0A, 8'h00); // TX_EN and RTS
        add_row(CH_A, OP_PINS, 5'd0, 8'h00, 8'b1110);
        add_row(CH_A, OP_CTS, 5'd0, 8'h01, 8'h00);
        add_row(CH_A, OP_WAIT, scc_reg_pkg::RR0, 8'h20, 8'h20);
        add_row(CH_A, OP_CTS, 5'd0, 8'h00, 8'h00);
        add_row(CH_A, OP_WAIT, scc_reg_pkg::RR0, 8'h20, 8'h00);
        add_row(CH_A, OP_CTS, 5'd0, 8'h01, 8'h00);
        add_row(CH_A, OP_WAIT, scc_reg_pkg::RR0, 8'h20, 8'h20);
        // Pointer protocol with random time constants
        for (int c = 1; c >= 0; c--) begin
            lo = 8'($urandom);
            hi = 8'($urandom);
            add_row(c[0], OP_WRITE, scc_reg_pkg::WR12_TC_LO, lo, 8'h00);
            add_row(c[0], OP_WRITE, scc_reg_pkg::WR13_TC_HI, hi, 8'h00);
            add_row(c[0], OP_READ, scc_reg_pkg::RR12, 8'h00, lo);
            add_row(c[0], OP_READ, scc_reg_pkg::RR13, 8'h00, hi);
        end
        add_row(CH_A, OP_READ, scc_reg_pkg::RR0, 8'h00, 8'h24);  // Pointer back at 0
        for (int c = 1; c >= 0; c--) begin
            add_row(c[0], OP_WRITE, scc_reg_pkg::WR12_TC_LO, 8'h00, 8'h00); // Fastest rate
            add_row(c[0], OP_WRITE, scc_reg_pkg::WR13_TC_HI, 8'h00, 8'h00);
        end
        // Local loopback on A
        add_row(CH_A, OP_WRITE, scc_reg_pkg::WR14_MISC, 8'h11, 8'h00);
        add_row(CH_A, OP_WRITE, scc_reg_pkg::WR3_RX, 8'h01, 8'h00);
        add_row(CH_A, OP_WATCH, 5'd0, 8'h01, 8'h00);
        for (int i = 0; i < 3; i++) begin
            b = 8'($urandom);
            add_row(CH_A, OP_WRITE, DATA_PORT, b, 8'h00);
            add_row(CH_A, OP_WAIT, scc_reg_pkg::RR0, 8'h01, 8'h01);
            add_row(CH_A, OP_READ, DATA_PORT, 8'h00, b);
        end
        add_row(CH_A, OP_WAIT, scc_reg_pkg::RR1, 8'h01, 8'h01);  // Last stop bit out
        add_row(CH_A, OP_WATCH, 5'd0, 8'h00, 8'h00);
        add_row(CH_A, OP_READ, scc_reg_pkg::RR0, 8'h00, 8'h24);
        // A to B, fourth byte overruns the 3-entry FIFO
        add_row(CH_A, OP_WRITE, scc_reg_pkg::WR14_MISC, 8'h01, 8'h00);
        add_row(CH_B, OP_WRITE, scc_reg_pkg::WR14_MISC, 8'h01, 8'h00);
        add_row(CH_B, OP_WRITE, scc_reg_pkg::WR3_RX, 8'h01, 8'h00);
        for (int i = 0; i < 4; i++) begin
            burst[i] = 8'($urandom);
            add_row(CH_A, OP_WRITE, DATA_PORT, burst[i], 8'h00);
            add_row(CH_A, OP_WAIT, scc_reg_pkg::RR0, 8'h04, 8'h04);
        end
        add_row(CH_A, OP_WAIT, scc_reg_pkg::RR1, 8'h01, 8'h01);
        add_row(CH_B, OP_STATUS, 5'd0, 8'h00, 8'b111010);   // Overrun set
        add_row(CH_B, OP_STATUS, 5'd0, 8'h00, 8'b111000);   // Cleared by the RR1 read
        for (int i = 0; i < 3; i++)
            add_row(CH_B, OP_READ, DATA_PORT, 8'h00, burst[i]);
        add_row(CH_B, OP_READ, scc_reg_pkg::RR0, 8'h00, 8'h04);
        // Receive interrupt on B
        add_row(CH_B, OP_WRITE, scc_reg_pkg::WR1_INT, 8'h10, 8'h00);
        add_row(CH_A, OP_IRQ, 5'd0, 8'h00, 8'h01);
        b = 8'($urandom);
        add_row(CH_A, OP_WRITE, DATA_PORT, b, 8'h00);
        add_row(CH_B, OP_WAIT, scc_reg_pkg::RR0, 8'h01, 8'h01);
        add_row(CH_A, OP_IRQ, 5'd0, 8'h00, 8'h00);
        add_row(CH_B, OP_READ, DATA_PORT, 8'h00, b);
        add_row(CH_A, OP_IRQ, 5'd0, 8'h00, 8'h01);
        // Transmit interrupt on A, buffer held full by CTS
        add_row(CH_A, OP_WRITE, scc_reg_pkg::WR1_INT, 8'h02, 8'h00);
        add_row(CH_A, OP_IRQ, 5'd0, 8'h00, 8'h00);
        add_row(CH_A, OP_CTS, 5'd0, 8'h00, 8'h00);
        add_row(CH_A, OP_WAIT, scc_reg_pkg::RR0, 8'h20, 8'h00);
        b = 8'($urandom);
        add_row(CH_A, OP_WRITE, DATA_PORT, b, 8'h00);
        add_row(CH_A, OP_IRQ, 5'd0, 8'h00, 8'h01);
        add_row(CH_A, OP_READ, scc_reg_pkg::RR0, 8'h00, 8'h00);
        add_row(CH_A, OP_CTS, 5'd0, 8'h01, 8'h00);
        add_row(CH_A, OP_WAIT, scc_reg_pkg::RR0, 8'h04, 8'h04);
        add_row(CH_A, OP_IRQ, 5'd0, 8'h00, 8'h00);
        add_row(CH_B, OP_WAIT, scc_reg_pkg::RR0, 8'h01, 8'h01);
        add_row(CH_B, OP_READ, DATA_PORT, 8'h00, b);
        add_row(CH_A, OP_WRITE, scc_reg_pkg::WR1_INT, 8'h00, 8'h00);
        add_row(CH_A, OP_IRQ, 5'd0, 8'h00, 8'h01);
        // Framing error from a hand-built frame, then a clean one
        add_row(CH_A, OP_WAIT, scc_reg_pkg::RR1, 8'h01, 8'h01);  // Link idle
        for (int s = 0; s < 2; s++) begin
            b = 8'($urandom);
            add_row(CH_B, OP_FRAME, 5'd0, b, 8'(s));             // Stop level
            add_row(CH_B, OP_WAIT, scc_reg_pkg::RR0, 8'h01, 8'h01);
            add_row(CH_B, OP_READ, DATA_PORT, 8'h00, b);
            add_row(CH_B, OP_STATUS, 5'd0, 8'h00, (s == 0) ? 8'b011001 : 8'b011000);
        end
        add_row(CH_B, OP_READ, scc_reg_pkg::RR1, 8'h00, 8'h01);
    endtask

    task automatic apply_row(input int idx, input row_t row);
        logic [7:0]                    value;
        scc_types_pkg::scc_ch_status_t st;
        string                         tag;
        tag = $sformatf("row %0d ch %s", idx, row.ch ? "A" : "B");
        case (row.op)
            OP_WRITE: reg_write(row.ch, row.regn, row.data);
            OP_READ: begin
                reg_read(row.ch, row.regn, value);
                check_byte(value, row.want, tag);
            end
            OP_WAIT:  poll_reg(row.ch, row.regn, row.data, row.want);
            OP_FRAME: send_frame(row.data, row.want[0]);
            OP_IRQ: begin
                @(posedge clk_14m);
                check_irq(irq_n, row.want[0], tag);
            end
            OP_STATUS: begin
                read_status(row.ch, st);
                check_status(st, scc_types_pkg::scc_ch_status_t'(row.want[5:0]), tag);
            end
            OP_PINS: begin
                @(posedge clk_14m);
                check_pins({txd_a, txd_b, rts_a, rts_b}, row.want[3:0], tag);
            end
            OP_CTS: begin
                @(posedge clk_14m);
                if (row.ch)
                    cts_a <= row.data[0];
                else
                    cts_b <= row.data[0];
            end
            OP_WATCH: begin
                @(posedge clk_14m);
                watch_txd <= row.data[0];
            end
        endcase
    endtask

    initial begin
        void'($urandom(70));
        clk_14m     = 1'b0;
        reset       = 1'b1;
        ph0_cnt     = 2'd0;
        ph0_en      = 1'b0;
        cs          = 1'b0;
        we          = 1'b0;
        rs          = 2'b00;
        wdata       = 8'h00;
        cts_a       = 1'b0;
        cts_b       = 1'b0;
        raw_sel     = 1'b0;
        raw_line    = 1'b1;
        watch_txd   = 1'b0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk_14m);
        reset <= 1'b0;
        repeat (2) @(posedge clk_14m);
        for (int i = 0; i < rows.size(); i++)
            apply_row(i, rows[i]);
        repeat (4) @(posedge clk_14m);
        $display("Errors: byte %0d, irq %0d, status %0d, pins %0d, line %0d", byte_errors,
                 irq_errors, status_errors, pin_errors, line_errors);
        if (byte_errors + irq_errors + status_errors + pin_errors + line_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial begin
        wait (table_ready);
        wait_timeout(rows.size());
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== verilog/scc_baud_gen.sv ====
`timescale 1ns/1ps

module scc_baud_gen (
    input  logic        clk_14m,
    input  logic        reset,
    input  logic        pclk_en,    // One clk_14m cycle in PCLK_DIV
    input  logic        enable,     // WR14 BRG enable
    input  logic [15:0] time_const, // {WR13, WR12}
    output logic        tick        // 16x bit-rate strobe
);
    logic [15:0] count;

    // Down-counter runs on PCLK enables only
    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (!enable) begin
            count <= time_const;       // Hold preloaded while stopped
        end else if (pclk_en) begin
            if (count == '0)
                count <= time_const;   // Reload on terminal count
            else
                count <= count - 1'b1;
        end
    end

    // TC + 1 enables per tick
    assign tick = enable && pclk_en && (count == '0);

endmodule

// ==== verilog/scc_channel.sv ====
`timescale 1ns/1ps

module scc_channel (
    input  logic                        clk_14m,
    input  logic                        reset,
    input  logic                        pclk_en,
    input  scc_types_pkg::scc_bus_req_t req,
    output logic [7:0]                  rdata,
    output logic                        irq_n,
    input  logic                        rxd,
    output logic                        txd,
    input  logic                        cts,
    output logic                        rts
);
    logic [3:0] ptr;                // WR0 register pointer
    logic [7:0] wr1, wr3, wr5, wr12, wr13, wr14;
    logic       overrun_q;
    logic       framing_q;
    logic       cts_s1, cts_s2;
    logic       ctrl_wr, ctrl_rd, rr1_rd;
    logic       tx_empty, tx_pop;
    logic [7:0] tx_head;
    logic       tx_line, all_sent, tick;
    logic       rx_line, rx_push, rx_pop, rx_empty, rx_full;
    logic [7:0] rr0, rr1, rd_mux;
    scc_types_pkg::scc_rx_entry_t  rx_entry;
    scc_types_pkg::scc_rx_entry_t  rx_head;
    scc_types_pkg::scc_ch_status_t status;

    assign ctrl_wr = req.wr && !req.data_sel;
    assign ctrl_rd = req.rd && !req.data_sel;
    assign rr1_rd  = ctrl_rd && (ptr == scc_reg_pkg::RR1);
    assign rx_pop  = req.rd && req.data_sel;

    // Pointer first, then the addressed register, then back to 0
    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            ptr  <= scc_reg_pkg::WR0_PTR;
            wr1  <= '0;
            wr3  <= '0;
            wr5  <= '0;
            wr12 <= '0;
            wr13 <= '0;
            wr14 <= '0;
        end else if (ctrl_wr) begin
            if (ptr == scc_reg_pkg::WR0_PTR) begin
                ptr <= req.wdata[3:0];
            end else begin
                ptr <= scc_reg_pkg::WR0_PTR;
                case (ptr)
                    scc_reg_pkg::WR1_INT:    wr1  <= req.wdata;
                    scc_reg_pkg::WR3_RX:     wr3  <= req.wdata;
                    scc_reg_pkg::WR5_TX:     wr5  <= req.wdata;
                    scc_reg_pkg::WR12_TC_LO: wr12 <= req.wdata;
                    scc_reg_pkg::WR13_TC_HI: wr13 <= req.wdata;
                    scc_reg_pkg::WR14_MISC:  wr14 <= req.wdata;
                    default: ;               // Unmodelled register drops the write
                endcase
            end
        end else if (ctrl_rd) begin
            ptr <= scc_reg_pkg::WR0_PTR;
        end
    end

    // Sticky receive errors clear when RR1 is read
    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            overrun_q <= 1'b0;
            framing_q <= 1'b0;
            cts_s1    <= 1'b0;
            cts_s2    <= 1'b0;
        end else begin
            cts_s1 <= cts;
            cts_s2 <= cts_s1;
            if (rr1_rd) begin
                overrun_q <= 1'b0;
                framing_q <= 1'b0;
            end
            if (rx_push && rx_full && !rx_pop)
                overrun_q <= 1'b1;                 // Character lost
            if (rx_pop && !rx_empty && rx_head.framing_err)
                framing_q <= 1'b1;                 // Keep the error past its data read
        end
    end

    assign status.rx_avail    = !rx_empty;
    assign status.tx_empty    = tx_empty;
    assign status.all_sent    = all_sent;
    assign status.cts         = cts_s2;
    assign status.overrun     = overrun_q;
    assign status.framing_err = framing_q || (!rx_empty && rx_head.framing_err);

    always_comb begin
        rr0 = '0;
        rr0[scc_reg_pkg::RR0_RX_AVAIL] = status.rx_avail;
        rr0[scc_reg_pkg::RR0_TX_EMPTY] = status.tx_empty;
        rr0[scc_reg_pkg::RR0_CTS]      = status.cts;
        rr1 = '0;
        rr1[scc_reg_pkg::RR1_ALL_SENT] = status.all_sent;
        rr1[scc_reg_pkg::RR1_OVERRUN]  = status.overrun;
        rr1[scc_reg_pkg::RR1_FRAMING]  = status.framing_err;
        if (req.data_sel)
            rd_mux = rx_head.data;
        else begin
            case (ptr)
                scc_reg_pkg::RR0:  rd_mux = rr0;
                scc_reg_pkg::RR1:  rd_mux = rr1;
                scc_reg_pkg::RR12: rd_mux = wr12;   // Time constant reads back
                scc_reg_pkg::RR13: rd_mux = wr13;
                default:           rd_mux = 8'h00;
            endcase
        end
    end

    // Read byte is captured on the strobe and held
    always_ff @(posedge clk_14m) begin
        if (req.rd)
            rdata <= rd_mux;
    end

    assign rts = wr5[scc_reg_pkg::WR5_RTS];
    // Loopback routes the shifter to the receiver and parks the pin at mark
    assign txd     = wr14[scc_reg_pkg::WR14_LOOPBACK] ? 1'b1 : tx_line;
    assign rx_line = wr14[scc_reg_pkg::WR14_LOOPBACK] ? tx_line : rxd;

    assign irq_n = !((wr1[scc_reg_pkg::WR1_RX_INT_EN] && status.rx_avail) ||
                     (wr1[scc_reg_pkg::WR1_TX_INT_EN] && status.tx_empty));

    scc_fifo #(
        .payload_t (logic [7:0]),
        .depth     (scc_reg_pkg::TX_FIFO_DEPTH)
    ) tx_fifo (
        .clk_14m   (clk_14m),
        .reset     (reset),
        .push      (req.wr && req.data_sel),
        .push_data (req.wdata),
        .pop       (tx_pop),
        .pop_data  (tx_head),
        .empty     (tx_empty),
        .full      ()
    );

    scc_fifo #(
        .payload_t (scc_types_pkg::scc_rx_entry_t),
        .depth     (scc_reg_pkg::RX_FIFO_DEPTH)
    ) rx_fifo (
        .clk_14m   (clk_14m),
        .reset     (reset),
        .push      (rx_push),
        .push_data (rx_entry),
        .pop       (rx_pop),
        .pop_data  (rx_head),
        .empty     (rx_empty),
        .full      (rx_full)
    );

    scc_baud_gen baud_gen (
        .clk_14m    (clk_14m),
        .reset      (reset),
        .pclk_en    (pclk_en),
        .enable     (wr14[scc_reg_pkg::WR14_BRG_EN]),
        .time_const ({wr13, wr12}),
        .tick       (tick)
    );

    scc_tx tx (
        .clk_14m    (clk_14m),
        .reset      (reset),
        .tick       (tick),
        .tx_en      (wr5[scc_reg_pkg::WR5_TX_EN]),
        .cts        (cts_s2),
        .data_valid (!tx_empty),
        .data       (tx_head),
        .data_pop   (tx_pop),
        .txd        (tx_line),
        .all_sent   (all_sent)
    );

    scc_rx rx (
        .clk_14m (clk_14m),
        .reset   (reset),
        .tick    (tick),
        .rx_en   (wr3[scc_reg_pkg::WR3_RX_EN]),
        .rxd     (rx_line),
        .push    (rx_push),
        .entry   (rx_entry)
    );

endmodule

// ==== verilog/scc_fifo.sv ====
`timescale 1ns/1ps

module scc_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 2
) (
    input  logic     clk_14m,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);
    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1; // Depth 1 still needs one bit
    localparam int CNT_W = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wrap at depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(depth));
    assign do_pop   = pop && !empty;
    assign do_push  = push && (!full || do_pop); // Full push only lands if a slot frees now
    assign pop_data = mem[rd_ptr];               // Head is visible before the pop

    always_ff @(posedge clk_14m) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                      // Both or neither keep the level
            endcase
        end
    end

endmodule

// ==== verilog/scc_iigs_wrapper.sv ====
`timescale 1ns/1ps

module scc_iigs_wrapper (
    input  logic       clk_14m,   // IIgs master clock
    input  logic       reset,
    input  logic       ph0_en,    // Bus phase enable
    input  logic       cs,        // C038..C03B decode
    input  logic       we,
    input  logic [1:0] rs,        // [1] data/ctl, [0] A/B
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic       irq_n,     // Active low, both channels combined
    output logic       txd_a,
    output logic       txd_b,
    input  logic       rxd_a,
    input  logic       rxd_b,
    output logic       rts_a,
    output logic       rts_b,
    input  logic       cts_a,
    input  logic       cts_b
);
    logic [2:0] clk_div;
    logic       pclk_en;
    logic       strobe;
    logic       last_a;            // Channel of the most recent read
    logic [7:0] rdata_a, rdata_b;
    logic       irq_n_a, irq_n_b;
    scc_types_pkg::scc_bus_req_t req_a;
    scc_types_pkg::scc_bus_req_t req_b;

    // PCLK enable, one cycle in eight
    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset)
            clk_div <= '0;
        else
            clk_div <= clk_div + 1'b1;
    end

    assign pclk_en = (clk_div == 3'(scc_reg_pkg::PCLK_DIV - 1));
    assign strobe  = ph0_en && cs;

    // Only the addressed channel sees the strobe
    assign req_a = '{wr: strobe && we && rs[0], rd: strobe && !we && rs[0],
                     data_sel: rs[1], wdata: wdata};
    assign req_b = '{wr: strobe && we && !rs[0], rd: strobe && !we && !rs[0],
                     data_sel: rs[1], wdata: wdata};

    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset)
            last_a <= 1'b0;
        else if (strobe && !we)
            last_a <= rs[0];
    end

    assign rdata = last_a ? rdata_a : rdata_b;
    assign irq_n = irq_n_a && irq_n_b;          // Wired-AND of the two requests

    scc_channel chan_a (
        .clk_14m (clk_14m),
        .reset   (reset),
        .pclk_en (pclk_en),
        .req     (req_a),
        .rdata   (rdata_a),
        .irq_n   (irq_n_a),
        .rxd     (rxd_a),
        .txd     (txd_a),
        .cts     (cts_a),
        .rts     (rts_a)
    );

    scc_channel chan_b (
        .clk_14m (clk_14m),
        .reset   (reset),
        .pclk_en (pclk_en),
        .req     (req_b),
        .rdata   (rdata_b),
        .irq_n   (irq_n_b),
        .rxd     (rxd_b),
        .txd     (txd_b),
        .cts     (cts_b),
        .rts     (rts_b)
    );

endmodule

// ==== verilog/scc_reg_pkg.sv ====
package scc_reg_pkg;

    // Write register numbers, as loaded into the WR0 pointer
    localparam logic [3:0] WR0_PTR    = 4'd0;
    localparam logic [3:0] WR1_INT    = 4'd1;
    localparam logic [3:0] WR3_RX     = 4'd3;
    localparam logic [3:0] WR5_TX     = 4'd5;
    localparam logic [3:0] WR12_TC_LO = 4'd12;
    localparam logic [3:0] WR13_TC_HI = 4'd13;
    localparam logic [3:0] WR14_MISC  = 4'd14;

    // Read register numbers
    localparam logic [3:0] RR0  = 4'd0;
    localparam logic [3:0] RR1  = 4'd1;
    localparam logic [3:0] RR12 = 4'd12;
    localparam logic [3:0] RR13 = 4'd13;

    // Control bits inside the write registers
    localparam int WR1_RX_INT_EN = 4;
    localparam int WR1_TX_INT_EN = 1;
    localparam int WR3_RX_EN     = 0;
    localparam int WR5_TX_EN     = 3;
    localparam int WR5_RTS       = 1;
    localparam int WR14_BRG_EN   = 0;
    localparam int WR14_LOOPBACK = 4;

    // Status bits inside the read registers
    localparam int RR0_RX_AVAIL = 0;
    localparam int RR0_TX_EMPTY = 2;
    localparam int RR0_CTS      = 5;
    localparam int RR1_ALL_SENT = 0;
    localparam int RR1_OVERRUN  = 5;
    localparam int RR1_FRAMING  = 6;

    localparam int PCLK_DIV      = 8;   // clk_14m cycles per PCLK enable
    localparam int OVERSAMPLE    = 16;  // Baud ticks per bit
    localparam int RX_FIFO_DEPTH = 3;
    localparam int TX_FIFO_DEPTH = 1;

endpackage

// ==== verilog/scc_rx.sv ====
`timescale 1ns/1ps

module scc_rx (
    input  logic                         clk_14m,
    input  logic                         reset,
    input  logic                         tick,
    input  logic                         rx_en,
    input  logic                         rxd,
    output logic                         push,
    output scc_types_pkg::scc_rx_entry_t entry
);
    localparam logic [3:0] MID = 4'(scc_reg_pkg::OVERSAMPLE / 2 - 1); // Mid-bit tick

    logic       rxd_s1;
    logic       rxd_s2;
    logic       active;
    logic [3:0] tick_cnt;  // Ticks since the falling edge, wraps per bit
    logic [3:0] bit_cnt;   // 0 = start, 1..8 = data, 9 = stop
    logic [7:0] shreg;
    logic       sample;

    // Line is asynchronous to clk_14m
    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            rxd_s1 <= 1'b1;
            rxd_s2 <= 1'b1;
        end else begin
            rxd_s1 <= rxd;
            rxd_s2 <= rxd_s1;
        end
    end

    assign sample = active && tick && (tick_cnt == MID);

    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            push     <= 1'b0;
        end else begin
            push <= 1'b0;
            if (!rx_en) begin
                active <= 1'b0;
            end else if (!active) begin
                if (tick && !rxd_s2) begin  // Candidate start edge
                    active   <= 1'b1;
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                end
            end else if (tick) begin
                tick_cnt <= tick_cnt + 1'b1;
                if (sample) begin
                    if (bit_cnt == 4'd0 && rxd_s2)
                        active <= 1'b0;      // Start bit gone at midpoint
                    else if (bit_cnt == 4'd9) begin
                        active <= 1'b0;
                        push   <= 1'b1;      // Character complete
                    end else
                        bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // Data shifter and completed entry
    always_ff @(posedge clk_14m) begin
        if (sample && bit_cnt != 4'd0 && bit_cnt != 4'd9)
            shreg <= {rxd_s2, shreg[7:1]};      // LSB first
        if (sample && bit_cnt == 4'd9) begin
            entry.data        <= shreg;
            entry.framing_err <= !rxd_s2;       // Low stop bit
        end
    end

endmodule

// ==== verilog/scc_tx.sv ====
`timescale 1ns/1ps

module scc_tx (
    input  logic       clk_14m,
    input  logic       reset,
    input  logic       tick,
    input  logic       tx_en,
    input  logic       cts,
    input  logic       data_valid, // Transmit buffer not empty
    input  logic [7:0] data,
    output logic       data_pop,
    output logic       txd,
    output logic       all_sent
);
    logic [9:0] shreg;    // {stop, data[7:0], start}, LSB goes out first
    logic [3:0] tick_cnt; // Ticks into the current bit
    logic [3:0] bit_cnt;  // Bit being sent, 0 = start, 9 = stop
    logic       busy;

    // Pull a byte only when idle and the far end is ready
    assign data_pop = !busy && tx_en && cts && data_valid;
    assign txd      = shreg[0];

    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            shreg    <= '1;   // Line idles high
            tick_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b0;
            all_sent <= 1'b1;
        end else if (data_pop) begin
            shreg    <= {1'b1, data, 1'b0};
            tick_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b1;
            all_sent <= 1'b0;
        end else if (busy && tick) begin
            tick_cnt <= tick_cnt + 1'b1;
            if (tick_cnt == 4'(scc_reg_pkg::OVERSAMPLE - 1)) begin
                shreg <= {1'b1, shreg[9:1]};   // Backfill with idle level
                if (bit_cnt == 4'd9) begin
                    busy     <= 1'b0;         // Stop bit done
                    all_sent <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/scc_types_pkg.sv ====
package scc_types_pkg;

    // One channel's view of a single bus strobe from the IIgs side
    typedef struct packed {
        logic       wr;         // Write strobe, one clk_14m cycle
        logic       rd;         // Read strobe, one clk_14m cycle
        logic       data_sel;   // 1 = data port, 0 = control/pointer port
        logic [7:0] wdata;      // Write byte
    } scc_bus_req_t;

    // Receive FIFO entry
    typedef struct packed {
        logic [7:0] data;        // Received character
        logic       framing_err; // Stop bit sampled low
    } scc_rx_entry_t;

    // Live channel flags, packed into RR0/RR1 by the channel
    typedef struct packed {
        logic rx_avail;     // At least one character waiting
        logic tx_empty;     // Transmit buffer can take a byte
        logic all_sent;     // Shifter idle after the stop bit
        logic cts;          // Synchronized CTS pin
        logic overrun;      // Sticky, receive FIFO was full
        logic framing_err;  // Sticky or head-of-FIFO framing error
    } scc_ch_status_t;

endpackage
